/* include/slc3_cfg.svh */
`ifndef SLC3_CFG_SVH
`define SLC3_CFG_SVH

// Memory-mapped I/O location
// Reads return the switches and writes go to the hex display register
`define SLC3_IO_ADDR 16'hFFFF

// General purpose registers R0 to R7
`define SLC3_NUM_REGS 8

// Flip-flop depth of the button and switch synchronizers
`define SLC3_SYNC_STAGES 2

// PC value after reset
`define SLC3_RESET_PC 16'h0000

`endif

/* src/slc3Pkg.sv */
package slc3Pkg;

	// LC-3 opcodes of the supported subset
	typedef enum logic [3:0] {
		OP_BR    = 4'b0000,
		OP_ADD   = 4'b0001,
		OP_JSR   = 4'b0100,
		OP_AND   = 4'b0101,
		OP_LDR   = 4'b0110,
		OP_STR   = 4'b0111,
		OP_NOT   = 4'b1001,
		OP_JMP   = 4'b1100,
		OP_PAUSE = 4'b1101
	} opcodeT;

	// Sequencer states
	typedef enum logic [4:0] {
		S_HALTED,
		S_FETCH_ADDR,
		S_FETCH_READ,
		S_FETCH_WAIT,
		S_LOAD_IR,
		S_DECODE,
		S_EXEC_ADD,
		S_EXEC_AND,
		S_EXEC_NOT,
		S_EXEC_BR,
		S_EXEC_JMP,
		S_EXEC_JSR,
		S_MEM_ADDR,
		S_MEM_READ,
		S_MEM_WAIT,
		S_LDR_LOAD,
		S_STR_DATA,
		S_MEM_WRITE,
		S_PAUSE
	} ctrlStateT;

	// Bus source encodings
	localparam logic [1:0] GATE_PC = 2'd0;
	localparam logic [1:0] GATE_MDR = 2'd1;
	localparam logic [1:0] GATE_ALU = 2'd2;
	localparam logic [1:0] GATE_MARMUX = 2'd3;

	// ALU operations, same order as LC-3 ALUK
	localparam logic [1:0] ALU_ADD = 2'd0;
	localparam logic [1:0] ALU_AND = 2'd1;
	localparam logic [1:0] ALU_NOT = 2'd2;
	localparam logic [1:0] ALU_PASSA = 2'd3;

	// PC sources
	localparam logic [1:0] PC_INC = 2'd0;
	localparam logic [1:0] PC_BUS = 2'd1;
	localparam logic [1:0] PC_ADDR = 2'd2;

	// ADDR2 offset selects
	localparam logic [1:0] OFF_ZERO = 2'd0;
	localparam logic [1:0] OFF_6 = 2'd1;
	localparam logic [1:0] OFF_9 = 2'd2;
	localparam logic [1:0] OFF_11 = 2'd3;

	// Datapath command word
	typedef struct packed {
		logic [1:0] gate;
		logic ldMar;
		logic ldMdr;
		logic ldIr;
		logic ldPc;
		logic ldReg;
		logic ldBen;
		logic ldCc;
		logic mioEn;      // MDR takes memory or switches, not the bus
		logic [1:0] pcMux;
		logic addr1Mux;   // 0 PC, 1 SR1
		logic [1:0] addr2Mux;
		logic sr1Mux;     // 0 IR[8:6], 1 IR[11:9]
		logic drMux;      // 0 IR[11:9], 1 R7
		logic sr2Imm;
		logic [1:0] aluOp;
	} ctrlT;

	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] wdata;
		logic rd;
		logic wr;
	} memReqT;

	typedef struct packed {
		logic [15:0] sw;
		logic run;
		logic cont;
	} panelT;

endpackage

/* src/panelInput.sv */
`timescale 1ns/1ps
`include "slc3_cfg.svh"

module panelInput
	import slc3Pkg::*;
(
	input logic Clk,
	input logic rstN,
	input logic Run,
	input logic Continue,
	input logic [15:0] S,
	output panelT panel
);

	// Bit 0 is Run and bit 1 is Continue
	logic [`SLC3_SYNC_STAGES-1:0][1:0] btnSync;
	logic [`SLC3_SYNC_STAGES-1:0][15:0] swSync;
	logic [1:0] pressD1;
	logic [1:0] pressD2;
	logic [1:0] pulse;

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			// Buttons idle high
			btnSync <= '1;
			swSync <= '0;
			pressD1 <= '0;
			pressD2 <= '0;
			pulse <= '0;
		end else begin
			btnSync[0] <= {Continue, Run};
			swSync[0] <= S;
			for (int i = 1; i < `SLC3_SYNC_STAGES; i++) begin
				btnSync[i] <= btnSync[i-1];
				swSync[i] <= swSync[i-1];
			end
			// Pressed level is the inverted synchronized button
			pressD1 <= ~btnSync[`SLC3_SYNC_STAGES-1];
			pressD2 <= pressD1;
			// One pulse per press, on the rising pressed level
			pulse <= pressD1 & ~pressD2;
		end
	end

	assign panel = '{sw: swSync[`SLC3_SYNC_STAGES-1], run: pulse[0], cont: pulse[1]};

endmodule

/* src/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit
	import slc3Pkg::*;
(
	input logic Clk,
	input logic rstN,
	input panelT panel,
	input logic [15:0] ir,
	input logic ben,
	output ctrlT ctrl,
	output logic memRd,
	output logic memWr,
	output logic paused
);

	ctrlStateT state;
	ctrlStateT stateNext;
	opcodeT opcode;

	assign opcode = opcodeT'(ir[15:12]);

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			state <= S_HALTED;
		end else begin
			state <= stateNext;
		end
	end

	// Next state
	always_comb begin
		stateNext = state;
		case (state)
			S_HALTED: begin
				if (panel.run) begin
					stateNext = S_FETCH_ADDR;
				end
			end
			S_FETCH_ADDR: stateNext = S_FETCH_READ;
			S_FETCH_READ: stateNext = S_FETCH_WAIT;
			S_FETCH_WAIT: stateNext = S_LOAD_IR;
			S_LOAD_IR: stateNext = S_DECODE;
			S_DECODE: begin
				case (opcode)
					OP_ADD: stateNext = S_EXEC_ADD;
					OP_AND: stateNext = S_EXEC_AND;
					OP_NOT: stateNext = S_EXEC_NOT;
					OP_BR: stateNext = S_EXEC_BR;
					OP_JMP: stateNext = S_EXEC_JMP;
					OP_JSR: stateNext = S_EXEC_JSR;
					OP_LDR, OP_STR: stateNext = S_MEM_ADDR;
					OP_PAUSE: stateNext = S_PAUSE;
					// Anything else is skipped
					default: stateNext = S_FETCH_ADDR;
				endcase
			end
			S_MEM_ADDR: stateNext = (opcode == OP_LDR) ? S_MEM_READ : S_STR_DATA;
			S_MEM_READ: stateNext = S_MEM_WAIT;
			S_MEM_WAIT: stateNext = S_LDR_LOAD;
			S_STR_DATA: stateNext = S_MEM_WRITE;
			S_PAUSE: begin
				if (panel.cont) begin
					stateNext = S_FETCH_ADDR;
				end
			end
			// Single-cycle execute states and the last LDR/STR steps
			default: stateNext = S_FETCH_ADDR;
		endcase
	end

	// Datapath commands per state
	always_comb begin
		ctrl = '0;
		memRd = 1'b0;
		memWr = 1'b0;
		paused = 1'b0;
		case (state)
			S_FETCH_ADDR: begin
				// MAR <- PC and PC <- PC + 1 together
				ctrl.gate = GATE_PC;
				ctrl.ldMar = 1'b1;
				ctrl.ldPc = 1'b1;
				ctrl.pcMux = PC_INC;
			end
			S_FETCH_READ, S_MEM_READ: memRd = 1'b1;
			S_FETCH_WAIT, S_MEM_WAIT: begin
				// Read data arrives this cycle
				ctrl.ldMdr = 1'b1;
				ctrl.mioEn = 1'b1;
			end
			S_LOAD_IR: begin
				ctrl.gate = GATE_MDR;
				ctrl.ldIr = 1'b1;
			end
			S_DECODE: ctrl.ldBen = 1'b1;
			S_EXEC_ADD, S_EXEC_AND, S_EXEC_NOT: begin
				ctrl.gate = GATE_ALU;
				ctrl.sr2Imm = ir[5];
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
				if (state == S_EXEC_ADD) begin
					ctrl.aluOp = ALU_ADD;
				end else if (state == S_EXEC_AND) begin
					ctrl.aluOp = ALU_AND;
				end else begin
					ctrl.aluOp = ALU_NOT;
				end
			end
			S_EXEC_BR: begin
				// PC already points past the branch
				ctrl.ldPc = ben;
				ctrl.pcMux = PC_ADDR;
				ctrl.addr2Mux = OFF_9;
			end
			S_EXEC_JMP: begin
				// BaseR plus zero
				ctrl.ldPc = 1'b1;
				ctrl.pcMux = PC_ADDR;
				ctrl.addr1Mux = 1'b1;
			end
			S_EXEC_JSR: begin
				// R7 gets the return PC in the same cycle as the jump
				ctrl.gate = GATE_PC;
				ctrl.drMux = 1'b1;
				ctrl.ldReg = 1'b1;
				ctrl.ldPc = 1'b1;
				ctrl.pcMux = PC_ADDR;
				ctrl.addr1Mux = ~ir[11];
				ctrl.addr2Mux = ir[11] ? OFF_11 : OFF_ZERO;
			end
			S_MEM_ADDR: begin
				// BaseR + offset6 for both LDR and STR
				ctrl.gate = GATE_MARMUX;
				ctrl.ldMar = 1'b1;
				ctrl.addr1Mux = 1'b1;
				ctrl.addr2Mux = OFF_6;
			end
			S_LDR_LOAD: begin
				ctrl.gate = GATE_MDR;
				ctrl.ldReg = 1'b1;
				ctrl.ldCc = 1'b1;
			end
			S_STR_DATA: begin
				// Source register is IR[11:9] through the ALU
				ctrl.gate = GATE_ALU;
				ctrl.aluOp = ALU_PASSA;
				ctrl.sr1Mux = 1'b1;
				ctrl.ldMdr = 1'b1;
			end
			S_MEM_WRITE: memWr = 1'b1;
			S_PAUSE: paused = 1'b1;
			default: ;
		endcase
	end

endmodule

/* src/dataPath.sv */
`timescale 1ns/1ps
`include "slc3_cfg.svh"

module dataPath
	import slc3Pkg::*;
(
	input logic Clk,
	input logic rstN,
	input ctrlT ctrl,
	input panelT panel,
	input logic [15:0] memRdata,
	output logic [15:0] memAddr,
	output logic [15:0] memWdata,
	output logic [15:0] ir,
	output logic [15:0] pc,
	output logic ben
);

	logic [15:0] mar;
	logic [15:0] mdr;
	logic [15:0] regFile [`SLC3_NUM_REGS];
	logic [2:0] nzp;

	logic [15:0] bus;
	logic [15:0] mdrIn;
	logic [15:0] pcIn;
	logic [15:0] sr1Data;
	logic [15:0] sr2Data;
	logic [15:0] aluB;
	logic [15:0] aluOut;
	logic [15:0] addr1;
	logic [15:0] addr2;
	logic [15:0] addrSum;
	logic [2:0] sr1Idx;
	logic [2:0] drIdx;

	// Register file read ports
	assign sr1Idx = ctrl.sr1Mux ? ir[11:9] : ir[8:6];
	assign drIdx = ctrl.drMux ? 3'(`SLC3_NUM_REGS - 1) : ir[11:9];
	assign sr1Data = regFile[sr1Idx];
	assign sr2Data = regFile[ir[2:0]];

	// ALU, B operand is SR2 or sign-extended imm5
	assign aluB = ctrl.sr2Imm ? {{11{ir[4]}}, ir[4:0]} : sr2Data;

	always_comb begin
		case (ctrl.aluOp)
			ALU_ADD: aluOut = sr1Data + aluB;
			ALU_AND: aluOut = sr1Data & aluB;
			ALU_NOT: aluOut = ~sr1Data;
			default: aluOut = sr1Data;
		endcase
	end

	// Address adder
	assign addr1 = ctrl.addr1Mux ? sr1Data : pc;

	always_comb begin
		case (ctrl.addr2Mux)
			OFF_6: addr2 = {{10{ir[5]}}, ir[5:0]};
			OFF_9: addr2 = {{7{ir[8]}}, ir[8:0]};
			OFF_11: addr2 = {{5{ir[10]}}, ir[10:0]};
			default: addr2 = 16'h0000;
		endcase
	end

	assign addrSum = addr1 + addr2;

	// Internal bus, one source at a time
	always_comb begin
		case (ctrl.gate)
			GATE_PC: bus = pc;
			GATE_MDR: bus = mdr;
			GATE_ALU: bus = aluOut;
			default: bus = addrSum;
		endcase
	end

	always_comb begin
		case (ctrl.pcMux)
			PC_BUS: pcIn = bus;
			PC_ADDR: pcIn = addrSum;
			default: pcIn = pc + 16'd1;
		endcase
	end

	// Memory side of MDR, I/O address reads the switches
	assign mdrIn = ctrl.mioEn ? ((mar == `SLC3_IO_ADDR) ? panel.sw : memRdata) : bus;

	// Architectural control state
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			pc <= `SLC3_RESET_PC;
			ir <= 16'h0000;
			nzp <= 3'b000;
			ben <= 1'b0;
		end else begin
			if (ctrl.ldPc) begin
				pc <= pcIn;
			end
			if (ctrl.ldIr) begin
				ir <= bus;
			end
			if (ctrl.ldCc) begin
				nzp <= {bus[15], bus == 16'h0000, !bus[15] && bus != 16'h0000};
			end
			if (ctrl.ldBen) begin
				ben <= |(ir[11:9] & nzp);
			end
		end
	end

	// Payload registers
	always_ff @(posedge Clk) begin
		if (ctrl.ldMar) begin
			mar <= bus;
		end
		if (ctrl.ldMdr) begin
			mdr <= mdrIn;
		end
		if (ctrl.ldReg) begin
			regFile[drIdx] <= bus;
		end
	end

	assign memAddr = mar;
	assign memWdata = mdr;

endmodule

/* src/hexDisplay.sv */
`timescale 1ns/1ps
`include "slc3_cfg.svh"

module hexDisplay (
	input logic Clk,
	input logic rstN,
	input logic memWr,
	input logic [15:0] memAddr,
	input logic [15:0] memWdata,
	input logic [15:0] pc,
	input logic [15:0] ir,
	input logic paused,
	output logic [11:0] LED,
	output logic [6:0] HEX0,
	output logic [6:0] HEX1,
	output logic [6:0] HEX2,
	output logic [6:0] HEX3,
	output logic [6:0] HEX4,
	output logic [6:0] HEX5,
	output logic [6:0] HEX6,
	output logic [6:0] HEX7
);

	logic [15:0] dispReg;

	// Active-low segments, gfedcba
	function automatic logic [6:0] hexSeg(input logic [3:0] nib);
		case (nib)
			4'h0: hexSeg = 7'b1000000;
			4'h1: hexSeg = 7'b1111001;
			4'h2: hexSeg = 7'b0100100;
			4'h3: hexSeg = 7'b0110000;
			4'h4: hexSeg = 7'b0011001;
			4'h5: hexSeg = 7'b0010010;
			4'h6: hexSeg = 7'b0000010;
			4'h7: hexSeg = 7'b1111000;
			4'h8: hexSeg = 7'b0000000;
			4'h9: hexSeg = 7'b0010000;
			4'hA: hexSeg = 7'b0001000;
			4'hB: hexSeg = 7'b0000011;
			4'hC: hexSeg = 7'b1000110;
			4'hD: hexSeg = 7'b0100001;
			4'hE: hexSeg = 7'b0000110;
			default: hexSeg = 7'b0001110;
		endcase
	endfunction

	// Stores to the I/O address land here
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			dispReg <= 16'h0000;
		end else if (memWr && memAddr == `SLC3_IO_ADDR) begin
			dispReg <= memWdata;
		end
	end

	// Lower digits show the display register
	assign HEX0 = hexSeg(dispReg[3:0]);
	assign HEX1 = hexSeg(dispReg[7:4]);
	assign HEX2 = hexSeg(dispReg[11:8]);
	assign HEX3 = hexSeg(dispReg[15:12]);

	// Upper digits always track PC
	assign HEX4 = hexSeg(pc[3:0]);
	assign HEX5 = hexSeg(pc[7:4]);
	assign HEX6 = hexSeg(pc[11:8]);
	assign HEX7 = hexSeg(pc[15:12]);

	// PAUSE operand visible only while paused
	assign LED = paused ? ir[11:0] : 12'h000;

endmodule

/* src/slc3.sv */
`timescale 1ns/1ps

module slc3
	import slc3Pkg::*;
(
	input logic Clk,
	input logic rstN,
	input logic Run,
	input logic Continue,
	input logic [15:0] S,
	output logic [15:0] memAddr,
	output logic [15:0] memWdata,
	output logic memRd,
	output logic memWr,
	input logic [15:0] memRdata,
	output logic [11:0] LED,
	output logic [6:0] HEX0,
	output logic [6:0] HEX1,
	output logic [6:0] HEX2,
	output logic [6:0] HEX3,
	output logic [6:0] HEX4,
	output logic [6:0] HEX5,
	output logic [6:0] HEX6,
	output logic [6:0] HEX7,
	output logic [15:0] IR,
	output logic [15:0] PC
);

	panelT panel;
	ctrlT ctrl;
	memReqT memReq;
	logic ben;
	logic paused;
	logic [15:0] dpAddr;
	logic [15:0] dpWdata;
	logic cuRd;
	logic cuWr;

	// Buttons and switches
	panelInput panel0 (
		.Clk(Clk), .rstN(rstN), .Run(Run), .Continue(Continue), .S(S), .panel(panel)
	);

	// Sequencer
	controlUnit ctrl0 (
		.Clk(Clk), .rstN(rstN), .panel(panel), .ir(IR), .ben(ben),
		.ctrl(ctrl), .memRd(cuRd), .memWr(cuWr), .paused(paused)
	);

	// Registers, ALU and bus
	dataPath dp0 (
		.Clk(Clk), .rstN(rstN), .ctrl(ctrl), .panel(panel), .memRdata(memRdata),
		.memAddr(dpAddr), .memWdata(dpWdata), .ir(IR), .pc(PC), .ben(ben)
	);

	// Address and data from the datapath, strobes from the sequencer
	assign memReq = '{addr: dpAddr, wdata: dpWdata, rd: cuRd, wr: cuWr};

	assign memAddr = memReq.addr;
	assign memWdata = memReq.wdata;
	assign memRd = memReq.rd;
	assign memWr = memReq.wr;

	// Seven-segment digits and LEDs
	hexDisplay disp0 (
		.Clk(Clk), .rstN(rstN), .memWr(memReq.wr), .memAddr(memReq.addr),
		.memWdata(memReq.wdata), .pc(PC), .ir(IR), .paused(paused), .LED(LED),
		.HEX0(HEX0), .HEX1(HEX1), .HEX2(HEX2), .HEX3(HEX3),
		.HEX4(HEX4), .HEX5(HEX5), .HEX6(HEX6), .HEX7(HEX7)
	);

endmodule

/* tests/slc3_chk.sv */
`timescale 1ns/1ps

module slc3_chk (
	input logic Clk,
	input logic rstN,
	input logic memRd,
	input logic memWr,
	input logic [11:0] LED
);

	// Bumped by every failing assertion
	int unsigned failCount = 0;

	// A cycle either reads or writes
	rdWrExclusive: assert property (@(posedge Clk) disable iff (!rstN) !(memRd && memWr))
		else begin
			$error("memRd and memWr high in the same cycle");
			failCount++;
		end

	// Read strobe lasts exactly one cycle
	rdSingleCycle: assert property (@(posedge Clk) disable iff (!rstN) memRd |=> !memRd)
		else begin
			$error("memRd high on two consecutive cycles");
			failCount++;
		end

	// Strobes and LEDs stay quiet in reset
	quietInReset: assert property (@(posedge Clk) !rstN |-> (!memRd && !memWr && LED == 12'h000))
		else begin
			$error("memRd, memWr or LED active during reset");
			failCount++;
		end

endmodule

/* tests/slc3Tb.sv */
`timescale 1ns/1ps
`include "slc3_cfg.svh"

module slc3Tb
	import slc3Pkg::*;
();

	// Active-low gfedcba segments, digit F first down to digit 0
	localparam logic [111:0] segTable = {
		7'b0001110, 7'b0000110, 7'b0100001, 7'b1000110,
		7'b0000011, 7'b0001000, 7'b0010000, 7'b0000000,
		7'b1111000, 7'b0000010, 7'b0010010, 7'b0011001,
		7'b0110000, 7'b0100100, 7'b1111001, 7'b1000000
	};

	logic Clk;
	logic rstN;
	logic Run;
	logic Continue;
	logic [15:0] S;
	logic [15:0] memAddr;
	logic [15:0] memWdata;
	logic memRd;
	logic memWr;
	logic [15:0] memRdata = 16'h0000;
	logic [11:0] LED;
	logic [6:0] HEX0;
	logic [6:0] HEX1;
	logic [6:0] HEX2;
	logic [6:0] HEX3;
	logic [6:0] HEX4;
	logic [6:0] HEX5;
	logic [6:0] HEX6;
	logic [6:0] HEX7;
	logic [15:0] IR;
	logic [15:0] PC;

	logic [15:0] mem [0:65535];
	// Records of three words: kind, address or value, data
	logic [15:0] trace [0:255];
	// Observed stores as {address, data}
	logic [31:0] storeQ [$];
	logic [31:0] lfsr = 32'h7ea5_6d71;

	slc3 dut0 (.*);

	bind slc3 slc3_chk chk0 (
		.Clk(Clk), .rstN(rstN), .memRd(memRd), .memWr(memWr), .LED(LED)
	);

	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	// Four digits of a 16-bit value, top nibble first
	function automatic logic [27:0] digits(input logic [15:0] v);
		digits = {segTable[v[15:12]*7 +: 7], segTable[v[11:8]*7 +: 7],
			segTable[v[7:4]*7 +: 7], segTable[v[3:0]*7 +: 7]};
	endfunction

	// Galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] nextLfsr(input logic [31:0] s);
		nextLfsr = (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0000_0000);
	endfunction

	task automatic checkValue(
		input string name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("RESULT: FAIL");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	task automatic reportTimeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("RESULT: FAIL");
		$fatal(1, "Timeout");
	endtask

	// 1 to 16 cycles from four LFSR bits
	task automatic pickDelay(output int cycles);
		logic [3:0] bits;
		bits = 4'h0;
		for (int i = 0; i < 4; i++) begin
			bits = {bits[2:0], lfsr[0]};
			lfsr = nextLfsr(lfsr);
		end
		cycles = int'(bits) + 1;
	endtask

	// Buttons are active low and held for a few cycles
	task automatic pressButton(input logic cont);
		@(posedge Clk);
		if (cont) begin
			Continue <= 1'b0;
		end else begin
			Run <= 1'b0;
		end
		repeat (3) @(posedge Clk);
		Run <= 1'b1;
		Continue <= 1'b1;
	endtask

	task automatic waitStore(output logic [31:0] rec);
		int n;
		n = 0;
		while (storeQ.size() == 0) begin
			if (n == 300) begin
				reportTimeout("an expected store");
			end
			@(negedge Clk);
			n++;
		end
		rec = storeQ.pop_front();
	endtask

	// Paused shows up as a nonzero PAUSE operand on LED
	task automatic waitPause();
		int n;
		n = 0;
		while (LED == 12'h000) begin
			if (n == 600) begin
				reportTimeout("the processor to pause");
			end
			@(negedge Clk);
			n++;
		end
	endtask

	task automatic waitFetch();
		int n;
		n = 0;
		while (!memRd) begin
			if (n == 60) begin
				reportTimeout("a fetch after Continue");
			end
			@(negedge Clk);
			n++;
		end
	endtask

	// Memory model, read data one cycle after the strobe
	always @(posedge Clk) begin
		if (memRd) begin
			memRdata <= mem[memAddr];
		end
		if (memWr) begin
			mem[memAddr] <= memWdata;
			storeQ.push_back({memAddr, memWdata});
		end
	end

	// Upper digits track PC at all times
	always @(negedge Clk) begin
		if (rstN) begin
			checkValue("PC digits", 32'(digits(PC)), 32'({HEX7, HEX6, HEX5, HEX4}));
		end
		checkValue("assertion failures", 32'd0, 32'(dut0.chk0.failCount));
	end

	initial begin
		int idx;
		int delay;
		logic [15:0] fillAddr;
		logic [15:0] kind;
		logic [15:0] a;
		logic [15:0] b;
		logic [31:0] rec;
		rstN = 1'b0;
		Run = 1'b1;
		Continue = 1'b1;
		S = 16'h0000;
		// Byte-swapped address, so no two words look alike
		for (int i = 0; i < 65536; i++) begin
			fillAddr = 16'(i);
			mem[i] = {fillAddr[7:0], fillAddr[15:8]} ^ 16'hA5C3;
		end
		for (int i = 0; i < 256; i++) begin
			trace[i] = 16'h0000;
		end
		$readmemh("tests/slc3_trace.txt", trace);
		// Program and data words
		for (idx = 0; idx < 254 && trace[idx] != 16'h0000; idx += 3) begin
			if (trace[idx] == 16'h0001) begin
				mem[trace[idx+1]] = trace[idx+2];
			end
		end
		repeat (4) @(posedge Clk);
		rstN <= 1'b1;
		// Halted until Run
		repeat (10) begin
			@(negedge Clk);
			checkValue("reset memRd", 32'd0, 32'(memRd));
			checkValue("reset memWr", 32'd0, 32'(memWr));
			checkValue("reset PC", 32'(`SLC3_RESET_PC), 32'(PC));
			checkValue("reset IR", 32'd0, 32'(IR));
			checkValue("reset LED", 32'd0, 32'(LED));
		end
		pressButton(1'b0);
		for (idx = 0; idx < 254 && trace[idx] != 16'h0000; idx += 3) begin
			kind = trace[idx];
			a = trace[idx+1];
			b = trace[idx+2];
			case (kind)
				16'h0001: ;
				16'h0002: begin
					pickDelay(delay);
					repeat (delay) @(posedge Clk);
					S <= a;
				end
				16'h0003: begin
					waitStore(rec);
					checkValue("store address", 32'(a), 32'(rec[31:16]));
					checkValue("store data", 32'(b), 32'(rec[15:0]));
				end
				16'h0004: begin
					waitPause();
					checkValue("pause opcode", 32'(OP_PAUSE), 32'(IR[15:12]));
					checkValue("pause LED", 32'(a), 32'(LED));
					// Must stay stopped until Continue
					pickDelay(delay);
					repeat (delay) begin
						@(negedge Clk);
						checkValue("no fetch while paused", 32'd0, 32'(memRd));
					end
					pressButton(1'b1);
					waitFetch();
				end
				16'h0005: begin
					checkValue("display digits", 32'(digits(a)),
						32'({HEX3, HEX2, HEX1, HEX0}));
				end
				16'h0006: checkValue("memory word", 32'(b), 32'(mem[a]));
				default: begin
					$display("Unknown trace record kind %h at entry %0d", kind, idx);
					$display("RESULT: FAIL");
					$fatal(1, "Bad trace");
				end
			endcase
		end
		// Every store must have been listed in the trace
		checkValue("unexpected stores", 32'd0, 32'(storeQ.size()));
		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* tests/slc3_trace.txt */
// kind addr data, hex. Kinds: 1 program or data word, 2 switch value, 3 expected store,
// 4 pause LED value, 5 display value, 6 final memory word, 0 end
// Program from 0000, data words at 0030 and 0031
1 0000 5DA0  1 0001 1DAF  1 0002 1DAF  1 0003 1DA2
1 0004 6390  1 0005 6591  1 0006 1642  1 0007 7798
1 0008 5842  1 0009 993F  1 000A 7999  1 000B 193B
1 000C 0801  1 000D 1921  1 000E 799A  1 000F 0401
1 0010 1921  1 0011 799B  1 0012 4803  1 0013 739E
1 0014 739E  1 0015 739E  1 0016 7F9C  1 0017 5B60
1 0018 1B7F  1 0019 D0A5  1 001A 6540  1 001B 759D
1 001C 16A1  1 001D 7740  1 001E C180  1 001F 739E
1 0020 D3C1  1 0021 0FFF  1 0030 1234  1 0031 0F0F
// ALU, branch and JSR results
3 0038 2143  3 0039 FDFB  3 003A FDF6  3 003B FDF7
3 003C 0013
// Switches read through the I/O address after the first PAUSE
2 BEEF 0000  4 00A5 0000
3 003D BEEF  3 FFFF BEF0  5 BEF0 0000
4 03C1 0000
6 0038 2143  6 003D BEEF  6 0031 0F0F
0 0000 0000

/* verilog.f */
+incdir+include
src/slc3Pkg.sv
src/panelInput.sv
src/controlUnit.sv
src/dataPath.sv
src/hexDisplay.sv
src/slc3.sv
tests/slc3_chk.sv
tests/slc3Tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP = slc3Tb
FILELIST = verilog.f
OBJDIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
